// File: vga_display_top.f
+incdir+.
vga_display_pkg.sv
vga_timing_gen.sv
pixel_fifo.sv
display_config.sv
pixel_compositor.sv
vga_display_top.sv
tb_vga_display_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the VGA display testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_vga_display_top \
    -f vga_display_top.f -o sim_vga > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_vga > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: tb_vga_display_top.sv
`include "vga_display_macros.svh"

module tb_vga_display_top;

    logic                       clk_vga;
    logic                       rst_n;
    logic                       pix_valid;
    vga_display_pkg::pixel565_t pix_data;
    logic                       credit;
    logic                       cfg_wr;
    logic [1:0]                 cfg_addr;
    logic [23:0]                cfg_wdata;
    logic [7:0]                 vga_r;
    logic [7:0]                 vga_g;
    logic [7:0]                 vga_b;
    logic                       hsync;
    logic                       vsync;
    logic                       blank_n;
    logic [11:0]                pixel_x;
    logic [11:0]                pixel_y;

    int   errors = 0;
    int   faults = 0;
    int   cycle = 0;
    int   credits = `FIFO_DEPTH;
    int   words_left = 0;
    int   h_fall = 0;
    int   v_fall = 0;
    bit   monitor_on = 1'b0;
    logic h_prev = 1'b1;
    logic v_prev = 1'b1;

    // Words written to the FIFO and the clock edge on which each was captured
    vga_display_pkg::pixel565_t    fifo_q[$];
    int                            edge_q[$];
    vga_display_pkg::display_cfg_t cfg_model;

    vga_display_top UUT (.*);

    always #20 clk_vga = ~clk_vga;

    initial begin
        #(5 * `H_TOTAL * `V_TOTAL * 40);
        faults++;
        $display("Timeout: the tests did not finish within five frames");
        $display("Mismatches: %0d, other failures: %0d", errors, faults);
        $display("Done: errors found");
        $finish;
    end

    task automatic check_rgb(input vga_display_pkg::rgb888_t expected, input logic [11:0] x,
                             input logic [11:0] y);
        vga_display_pkg::rgb888_t actual;
        actual = {vga_r, vga_g, vga_b};
        if (actual !== expected) begin
            errors++;
            $display("Mismatch rgb at x %0d y %0d: got %h, expected %h", x, y, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_credits(input int actual, input int expected);
        if (actual != expected) begin
            errors++;
            $display("Mismatch credits: got %h, expected %h", actual, expected);
        end
    endtask

    task automatic check_period(input string name, input int actual, input int expected);
        if (actual != expected) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // Each channel scaled up to 8 bits with its top bits filling the gap
    function automatic vga_display_pkg::rgb888_t widen(input vga_display_pkg::pixel565_t p);
        vga_display_pkg::rgb888_t c;
        c.r = 8'((int'(p.r) << 3) | (int'(p.r) >> 2));
        c.g = 8'((int'(p.g) << 2) | (int'(p.g) >> 4));
        c.b = 8'((int'(p.b) << 3) | (int'(p.b) >> 2));
        return c;
    endfunction

    // Camera producer spends a credit per word and takes back each returned one
    always @(posedge clk_vga) begin : producer
        vga_display_pkg::pixel565_t word;
        cycle = cycle + 1;
        pix_valid <= 1'b0;
        if (rst_n && credit) begin
            credits = credits + 1;
            if (credits > `FIFO_DEPTH) begin
                check_credits(credits, `FIFO_DEPTH);
            end
        end
        if (rst_n && words_left > 0 && credits > 0) begin
            word = vga_display_pkg::pixel565_t'(16'($urandom));
            pix_valid <= 1'b1;
            pix_data  <= word;
            fifo_q.push_back(word);
            edge_q.push_back(cycle + 1);
            credits = credits - 1;
            words_left = words_left - 1;
        end
    end

    // The beat at edge N shows the position presented at edge N-1
    always @(negedge clk_vga) begin : monitor
        vga_display_pkg::rgb888_t   expected;
        vga_display_pkg::pixel565_t word;
        logic                       active;
        logic                       in_win;
        if (monitor_on) begin
            active = (pixel_x < `H_ACTIVE) && (pixel_y < `V_ACTIVE);
            in_win = (pixel_x >= `WIN_X0) && (pixel_x < `WIN_X1) &&
                     (pixel_y >= `WIN_Y0) && (pixel_y < `WIN_Y1);
            check_bit("blank_n", blank_n, active);
            if (!active) begin
                expected = '0;
            end else if (!in_win) begin
                expected = cfg_model.border;
            end else if (fifo_q.size() > 0 && edge_q[0] <= cycle - 1) begin
                word = fifo_q.pop_front();
                void'(edge_q.pop_front());
                if (!cfg_model.sobel_en) begin
                    expected = widen(word);
                end else if (word[7:0] >= cfg_model.threshold) begin
                    expected = 24'hffffff;
                end else begin
                    expected = '0;
                end
            end else if (pixel_x[4] ^ pixel_y[4]) begin
                expected = 24'hff0000;
            end else begin
                expected = 24'h00ff00;
            end
            check_rgb(expected, pixel_x, pixel_y);
            if (!hsync && h_prev) begin
                check_period("hsync start x", int'(pixel_x), `H_ACTIVE + `H_FRONT);
                if (h_fall > 0) begin
                    check_period("line length", cycle - h_fall, `H_TOTAL);
                end
                h_fall = cycle;
            end
            if (hsync && !h_prev) begin
                check_period("hsync low length", cycle - h_fall, `H_SYNC);
            end
            if (!vsync && v_prev) begin
                check_period("vsync start y", int'(pixel_y), `V_ACTIVE + `V_FRONT);
                if (v_fall > 0) begin
                    check_period("frame length", cycle - v_fall, `H_TOTAL * `V_TOTAL);
                end
                v_fall = cycle;
            end
            if (vsync && !v_prev) begin
                check_period("vsync low length", cycle - v_fall, `V_SYNC * `H_TOTAL);
            end
        end
        h_prev = hsync;
        v_prev = vsync;
    end

    task automatic wait_vblank;
        @(negedge clk_vga);
        while (!(pixel_y == `V_ACTIVE && pixel_x == 0)) begin
            @(negedge clk_vga);
        end
    endtask

    task automatic write_cfg(input logic [1:0] addr, input logic [23:0] data);
        @(posedge clk_vga);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk_vga);
        cfg_wr    <= 1'b0;
    endtask

    task automatic reset_values;
        repeat (3) @(posedge clk_vga);
        @(negedge clk_vga);
        check_rgb('0, pixel_x, pixel_y);
        check_bit("blank_n", blank_n, 1'b0);
        check_bit("hsync", hsync, 1'b1);
        check_bit("vsync", vsync, 1'b1);
        check_bit("credit", credit, 1'b0);
        @(posedge clk_vga);
        rst_n <= 1'b1;
        // First beat after reset still carries the reset position
        repeat (2) @(posedge clk_vga);
        monitor_on = 1'b1;
    endtask

    task automatic border_change;
        logic [23:0] colour;
        colour = 24'($urandom);
        wait_vblank();
        write_cfg(`REG_BORDER, colour);
        cfg_model.border = colour;
        wait_vblank();
    endtask

    task automatic camera_stream(input int n);
        words_left = n;
        wait_vblank();
        if (fifo_q.size() != 0 || words_left != 0) begin
            faults++;
            $display("Camera words were still unshown at the end of the frame");
        end
    endtask

    task automatic sobel_stream(input int n);
        logic [7:0] thr;
        thr = 8'($urandom);
        write_cfg(`REG_MODE, 24'h000001);
        write_cfg(`REG_THRESH, {16'h0000, thr});
        cfg_model.sobel_en  = 1'b1;
        cfg_model.threshold = thr;
        camera_stream(n);
    endtask

    task automatic credit_drain;
        repeat (4) @(posedge clk_vga);
        check_credits(credits, `FIFO_DEPTH);
    endtask

    initial begin
        clk_vga   = 1'b0;
        rst_n     = 1'b0;
        pix_valid = 1'b0;
        pix_data  = '0;
        cfg_wr    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        cfg_model = '{sobel_en: 1'b0, threshold: 8'h80, border: `BORDER_RESET};
        void'($urandom(32'h470c));
        reset_values();
        border_change();
        camera_stream(40);
        sobel_stream(40);
        credit_drain();
        $display("Mismatches: %0d, other failures: %0d", errors, faults);
        if (errors == 0 && faults == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: vga_display_top.sv
module vga_display_top (
    input  logic                       clk_vga,
    input  logic                       rst_n,
    input  logic                       pix_valid,
    input  vga_display_pkg::pixel565_t pix_data,
    output logic                       credit,
    input  logic                       cfg_wr,
    input  logic [1:0]                 cfg_addr,
    input  logic [23:0]                cfg_wdata,
    output logic [7:0]                 vga_r,
    output logic [7:0]                 vga_g,
    output logic [7:0]                 vga_b,
    output logic                       hsync,
    output logic                       vsync,
    output logic                       blank_n,
    output logic [11:0]                pixel_x,
    output logic [11:0]                pixel_y
);

    vga_display_pkg::vga_timing_t  timing;
    vga_display_pkg::display_cfg_t cfg;
    vga_display_pkg::pixel565_t    head;
    vga_display_pkg::rgb888_t      rgb;
    logic                          empty;
    logic                          pop;

    vga_timing_gen u_timing (
        .clk_vga (clk_vga),
        .rst_n   (rst_n),
        .timing  (timing)
    );

    pixel_fifo u_fifo (
        .clk_vga   (clk_vga),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .credit    (credit)
    );

    display_config u_config (
        .clk_vga   (clk_vga),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    pixel_compositor u_compositor (
        .clk_vga (clk_vga),
        .rst_n   (rst_n),
        .timing  (timing),
        .cfg     (cfg),
        .head    (head),
        .empty   (empty),
        .pop     (pop),
        .rgb     (rgb),
        .hsync   (hsync),
        .vsync   (vsync),
        .blank_n (blank_n),
        .pixel_x (pixel_x),
        .pixel_y (pixel_y)
    );

    // DAC channels
    assign vga_r = rgb.r;
    assign vga_g = rgb.g;
    assign vga_b = rgb.b;

endmodule

// File: pixel_compositor.sv
`include "vga_display_macros.svh"

module pixel_compositor (
    input  logic                          clk_vga,
    input  logic                          rst_n,
    input  vga_display_pkg::vga_timing_t  timing,
    input  vga_display_pkg::display_cfg_t cfg,
    input  vga_display_pkg::pixel565_t    head,
    input  logic                          empty,
    output logic                          pop,
    output vga_display_pkg::rgb888_t      rgb,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          blank_n,
    output logic [11:0]                   pixel_x,
    output logic [11:0]                   pixel_y
);

    logic                     in_win;
    logic [15:0]              head_raw;
    vga_display_pkg::rgb888_t rgb_next;

    assign in_win = (timing.x >= 12'(`WIN_X0)) && (timing.x < 12'(`WIN_X1)) &&
                    (timing.y >= 12'(`WIN_Y0)) && (timing.y < 12'(`WIN_Y1));

    // Consume a word only for a visible window pixel with data ready
    assign pop = timing.video_on && in_win && !empty;

    assign head_raw = head;

    always_comb begin
        rgb_next = '0;
        if (!timing.video_on) begin
            rgb_next = '0;
        end else if (!in_win) begin
            rgb_next = cfg.border;
        end else if (empty) begin
            // FIFO ran dry, 16x16 red/green checkerboard
            if (timing.x[4] ^ timing.y[4]) begin
                rgb_next = '{r: 8'hff, g: 8'h00, b: 8'h00};
            end else begin
                rgb_next = '{r: 8'h00, g: 8'hff, b: 8'h00};
            end
        end else if (cfg.sobel_en) begin
            // Low byte carries the gradient magnitude
            if (head_raw[7:0] >= cfg.threshold) begin
                rgb_next = '{r: 8'hff, g: 8'hff, b: 8'hff};
            end else begin
                rgb_next = '0;
            end
        end else begin
            // Widen by replicating the top bits into the low bits
            rgb_next.r = {head.r, head.r[4:2]};
            rgb_next.g = {head.g, head.g[5:4]};
            rgb_next.b = {head.b, head.b[4:2]};
        end
    end

    // Output stage keeps colour, syncs and coordinates on the same beat
    always_ff @(posedge clk_vga or negedge rst_n) begin
        if (!rst_n) begin
            rgb     <= '0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            blank_n <= 1'b0;
            pixel_x <= '0;
            pixel_y <= '0;
        end else begin
            rgb     <= rgb_next;
            hsync   <= timing.hsync;
            vsync   <= timing.vsync;
            blank_n <= timing.video_on;
            pixel_x <= timing.x;
            pixel_y <= timing.y;
        end
    end

endmodule

// File: display_config.sv
`include "vga_display_macros.svh"

module display_config (
    input  logic                         clk_vga,
    input  logic                         rst_n,
    input  logic                         cfg_wr,
    input  logic [1:0]                   cfg_addr,
    input  logic [23:0]                  cfg_wdata,
    output vga_display_pkg::display_cfg_t cfg
);

    always_ff @(posedge clk_vga or negedge rst_n) begin
        if (!rst_n) begin
            cfg.sobel_en  <= 1'b0;
            cfg.threshold <= 8'h80;
            cfg.border    <= vga_display_pkg::rgb888_t'(`BORDER_RESET);
        end else if (cfg_wr) begin
            case (cfg_addr)
                `REG_MODE: begin
                    cfg.sobel_en <= cfg_wdata[0];
                end
                `REG_THRESH: begin
                    cfg.threshold <= cfg_wdata[7:0];
                end
                `REG_BORDER: begin
                    cfg.border <= vga_display_pkg::rgb888_t'(cfg_wdata);
                end
                default: begin
                    // Unmapped address, write dropped
                    cfg <= cfg;
                end
            endcase
        end
    end

    // The bus master must present a valid address with every write
    assert property (@(posedge clk_vga) disable iff (!rst_n)
        cfg_wr |-> !$isunknown(cfg_addr));

endmodule

// File: pixel_fifo.sv
`include "vga_display_macros.svh"

module pixel_fifo (
    input  logic                      clk_vga,
    input  logic                      rst_n,
    input  logic                      pix_valid,
    input  vga_display_pkg::pixel565_t pix_data,
    input  logic                      pop,
    output vga_display_pkg::pixel565_t head,
    output logic                      empty,
    output logic                      credit
);

    localparam int AW = $clog2(`FIFO_DEPTH);
    localparam int CW = $clog2(`FIFO_DEPTH + 1);

    vga_display_pkg::pixel565_t mem [`FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign full  = (count == CW'(`FIFO_DEPTH));
    assign empty = (count == '0);
    assign wr_en = pix_valid && !full;
    assign rd_en = pop && !empty;

    // Oldest word falls through to the output
    assign head = mem[rd_ptr];

    always_ff @(posedge clk_vga) begin
        if (wr_en) begin
            mem[wr_ptr] <= pix_data;
        end
    end

    always_ff @(posedge clk_vga or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            // Hand one credit back to the producer per consumed word
            credit <= rd_en;
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer must stay within its credits
    assert property (@(posedge clk_vga) disable iff (!rst_n) pix_valid |-> !full);

    // Compositor may only consume a word that is there
    assert property (@(posedge clk_vga) disable iff (!rst_n) pop |-> !empty);

endmodule

// File: vga_timing_gen.sv
`include "vga_display_macros.svh"

module vga_timing_gen (
    input  logic                        clk_vga,
    input  logic                        rst_n,
    output vga_display_pkg::vga_timing_t timing
);

    logic [11:0] h_cnt;
    logic [11:0] v_cnt;
    logic        h_end;
    logic        v_end;

    vga_display_pkg::vga_timing_t timing_next;

    assign h_end = (h_cnt == 12'(`H_TOTAL - 1));
    assign v_end = (v_cnt == 12'(`V_TOTAL - 1));

    // Free-running line and frame counters
    always_ff @(posedge clk_vga or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_end) begin
                h_cnt <= '0;
                if (v_end) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 12'd1;
                end
            end else begin
                h_cnt <= h_cnt + 12'd1;
            end
        end
    end

    // Sync pulses are active low, placed after the front porch
    always_comb begin
        timing_next.hsync    = !((h_cnt >= 12'(`H_ACTIVE + `H_FRONT)) &&
                                 (h_cnt <  12'(`H_ACTIVE + `H_FRONT + `H_SYNC)));
        timing_next.vsync    = !((v_cnt >= 12'(`V_ACTIVE + `V_FRONT)) &&
                                 (v_cnt <  12'(`V_ACTIVE + `V_FRONT + `V_SYNC)));
        timing_next.video_on = (h_cnt < 12'(`H_ACTIVE)) && (v_cnt < 12'(`V_ACTIVE));
        timing_next.x        = h_cnt;
        timing_next.y        = v_cnt;
    end

    always_ff @(posedge clk_vga or negedge rst_n) begin
        if (!rst_n) begin
            timing.hsync    <= 1'b1;
            timing.vsync    <= 1'b1;
            timing.video_on <= 1'b0;
            timing.x        <= '0;
            timing.y        <= '0;
        end else begin
            timing <= timing_next;
        end
    end

endmodule

// File: vga_display_pkg.sv
package vga_display_pkg;

    // Camera word as delivered by the sensor, RGB565
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pixel565_t;

    // Colour as driven to the DAC
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // One screen position with its sync state
    typedef struct packed {
        logic        hsync;
        logic        vsync;
        logic        video_on;
        logic [11:0] x;
        logic [11:0] y;
    } vga_timing_t;

    // Compositor controls
    typedef struct packed {
        logic       sobel_en;
        logic [7:0] threshold;
        rgb888_t    border;
    } display_cfg_t;

endpackage

// File: vga_display_macros.svh
`ifndef VGA_DISPLAY_MACROS_SVH
`define VGA_DISPLAY_MACROS_SVH

// Horizontal timing, in pixel clocks
`define H_ACTIVE 640
`define H_FRONT  16
`define H_SYNC   96
`define H_BACK   48
`define H_TOTAL  800

// Vertical timing, in lines
`define V_ACTIVE 480
`define V_FRONT  10
`define V_SYNC   2
`define V_BACK   33
`define V_TOTAL  525

// Camera window, upper bounds exclusive
`define WIN_X0 160
`define WIN_X1 480
`define WIN_Y0 120
`define WIN_Y1 360

// Pixel FIFO
`define FIFO_DEPTH 16

// Configuration register map
`define REG_MODE   2'd0
`define REG_THRESH 2'd1
`define REG_BORDER 2'd2

`define BORDER_RESET 24'h000080

`endif
